/* src/rvf_macros.svh */
`ifndef RVF_MACROS_SVH
`define RVF_MACROS_SVH

// data path and pc width
`define RVF_XLEN      32

// first fetch address after reset
`define RVF_RESET_PC  32'h8000_0000

// major opcodes the front end cares about
`define RVF_OP_JAL    7'b1101111
`define RVF_OP_JALR   7'b1100111
`define RVF_OP_OP     7'b0110011

// M extension encodings
`define RVF_F7_MULDIV 7'b0000001
`define RVF_F3_MUL    3'b000
`define RVF_F3_DIVU   3'b101

// addi x0, x0, 0
`define RVF_NOP       32'h0000_0013

`endif

/* src/rvf_pkg.sv */
package rvf_pkg;

    // what decode makes of a fetched word
    typedef enum logic [2:0] {
        CLS_PLAIN = 3'd0,  // anything that falls through to pc + 4
        CLS_JAL   = 3'd1,
        CLS_JALR  = 3'd2,  // rs1 taken as x0
        CLS_MUL   = 3'd3,
        CLS_DIV   = 3'd4   // unsigned divide
    } instr_class_e;

    // multi-cycle tracker in the pc stage
    typedef enum logic [1:0] {
        PC_IDLE  = 2'd0,
        PC_ARITH = 2'd1,  // muldiv running
        PC_AFTER = 2'd2,  // result back, commit still to come
        PC_END   = 2'd3   // step past the muldiv instruction
    } pc_state_e;

endpackage

/* src/rvf_pc_gen.sv */
`timescale 1ns/10ps
`include "rvf_macros.svh"

module rvf_pc_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mem_stall,
    input  logic                 redirect,
    input  logic [`RVF_XLEN-1:0] redirect_pc,
    input  logic                 jalr_pending,
    input  logic                 md_start,
    input  logic                 md_done,
    input  logic                 retire,
    input  logic                 fetch_ready,
    output logic                 fetch_req,
    output logic [`RVF_XLEN-1:0] fetch_pc
);
    import rvf_pkg::*;

    localparam logic [`RVF_XLEN-1:0] INSTR_BYTES = 4;

    pc_state_e            state_q;
    pc_state_e            state_d;
    logic [`RVF_XLEN-1:0] pc_q;        // pc of the instruction in flight
    logic                 started_q;
    logic                 have_cur_q;  // word at pc_q already requested
    logic                 have_nxt_q;  // word at pc_q + 4 requested ahead
    logic                 hold;
    logic                 take;

    // idle -> arith -> after -> end -> idle around every mul / divu
    always_comb begin
        state_d = state_q;
        case (state_q)
            PC_IDLE:  if (md_start) state_d = PC_ARITH;
            PC_ARITH: if (md_done) state_d = PC_AFTER;
            PC_AFTER: if (retire) state_d = PC_END;
            PC_END:   state_d = PC_IDLE;
            default:  state_d = PC_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= PC_IDLE;
            started_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            started_q <= 1'b1;  // one quiet cycle out of reset
        end
    end

    // anything that makes the next address uncertain blocks a request
    assign hold = mem_stall || jalr_pending || redirect || md_start || (state_q != PC_IDLE);

    assign fetch_req = started_q && !hold && !(have_cur_q && have_nxt_q);
    assign fetch_pc  = have_cur_q ? pc_q + INSTR_BYTES : pc_q;
    assign take      = fetch_req && fetch_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q       <= `RVF_RESET_PC;
            have_cur_q <= 1'b0;
            have_nxt_q <= 1'b0;
        end else if (redirect) begin
            pc_q       <= redirect_pc;
            have_cur_q <= 1'b0;
            have_nxt_q <= 1'b0;
        end else if (state_q == PC_END) begin
            // prefetch was flushed when the muldiv started
            pc_q       <= pc_q + INSTR_BYTES;
            have_cur_q <= 1'b0;
            have_nxt_q <= 1'b0;
        end else if (retire && state_q == PC_IDLE) begin
            pc_q       <= pc_q + INSTR_BYTES;
            have_cur_q <= have_nxt_q || take;  // prefetch becomes current
            have_nxt_q <= 1'b0;
        end else begin
            if (md_start) begin
                have_nxt_q <= 1'b0;  // decode dropped the prefetch
            end else if (take && have_cur_q) begin
                have_nxt_q <= 1'b1;
            end
            if (take && !have_cur_q) begin
                have_cur_q <= 1'b1;
            end
        end
    end

endmodule

/* src/rvf_fetch_apb.sv */
`timescale 1ns/10ps
`include "rvf_macros.svh"

module rvf_fetch_apb (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_req,
    input  logic [`RVF_XLEN-1:0] fetch_pc,
    input  logic                 flush,
    input  logic [`RVF_XLEN-1:0] prdata,
    input  logic                 pready,
    input  logic                 pslverr,
    output logic                 fetch_ready,
    output logic                 psel,
    output logic                 penable,
    output logic [`RVF_XLEN-1:0] paddr,
    output logic                 pwrite,
    output logic                 instr_valid,
    output logic [`RVF_XLEN-1:0] instr_pc,
    output logic [`RVF_XLEN-1:0] instr_word
);

    typedef enum logic [1:0] {
        F_IDLE   = 2'd0,
        F_SETUP  = 2'd1,
        F_ACCESS = 2'd2
    } fetch_state_e;

    fetch_state_e state_q;
    logic         stale_q;  // current access was flushed
    logic         done;
    logic         take;

    assign done        = (state_q == F_ACCESS) && pready;
    assign fetch_ready = (state_q == F_IDLE) || done;  // back to back on completion
    assign take        = fetch_req && fetch_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= F_IDLE;
            stale_q <= 1'b0;
        end else begin
            case (state_q)
                F_IDLE:   if (take) state_q <= F_SETUP;
                F_SETUP:  state_q <= F_ACCESS;
                F_ACCESS: begin
                    if (pready) begin
                        state_q <= take ? F_SETUP : F_IDLE;
                    end
                end
                default:  state_q <= F_IDLE;
            endcase

            if (take) begin
                stale_q <= 1'b0;
            end else if (flush && state_q != F_IDLE) begin
                stale_q <= 1'b1;  // let it finish, drop the data
            end
        end
    end

    // address held through setup and access
    always_ff @(posedge clk) begin
        if (take) begin
            paddr <= fetch_pc;
        end
    end

    assign psel    = (state_q != F_IDLE);
    assign penable = (state_q == F_ACCESS);
    assign pwrite  = 1'b0;  // read only port

    assign instr_valid = done && !stale_q;
    assign instr_pc    = paddr;
    // a failed read turns into a harmless nop
    assign instr_word  = pslverr ? `RVF_NOP : prdata;

endmodule

/* src/rvf_decode.sv */
`timescale 1ns/10ps
`include "rvf_macros.svh"

module rvf_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  logic [`RVF_XLEN-1:0]  instr_pc,
    input  logic [`RVF_XLEN-1:0]  instr_word,
    input  logic                  md_done,
    input  logic [`RVF_XLEN-1:0]  md_result,
    input  logic [`RVF_XLEN-1:0]  md_a,
    input  logic [`RVF_XLEN-1:0]  md_b,
    output logic                  redirect,
    output logic [`RVF_XLEN-1:0]  redirect_pc,
    output logic                  jalr_pending,
    output logic                  flush,
    output logic                  md_start,
    output logic                  md_is_div,
    output logic [`RVF_XLEN-1:0]  md_a_q,
    output logic [`RVF_XLEN-1:0]  md_b_q,
    output logic                  retire,
    output logic                  commit_valid,
    output logic [`RVF_XLEN-1:0]  commit_pc,
    output rvf_pkg::instr_class_e commit_cls,
    output logic [`RVF_XLEN-1:0]  commit_result
);
    import rvf_pkg::*;

    instr_class_e         cls;
    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`RVF_XLEN-1:0] j_imm;
    logic [`RVF_XLEN-1:0] i_imm;
    logic                 md_wait_q;  // muldiv in progress, commit held back
    logic                 accept;

    assign opcode = instr_word[6:0];
    assign funct3 = instr_word[14:12];
    assign funct7 = instr_word[31:25];
    assign j_imm  = {{11{instr_word[31]}}, instr_word[31], instr_word[19:12],
                     instr_word[20], instr_word[30:21], 1'b0};
    assign i_imm  = {{20{instr_word[31]}}, instr_word[31:20]};

    always_comb begin
        cls = CLS_PLAIN;  // branches, loads, stores all fall through
        case (opcode)
            `RVF_OP_JAL:  cls = CLS_JAL;
            `RVF_OP_JALR: begin
                if (funct3 == 3'b000) begin
                    cls = CLS_JALR;
                end
            end
            `RVF_OP_OP: begin
                if (funct7 == `RVF_F7_MULDIV && funct3 == `RVF_F3_MUL) begin
                    cls = CLS_MUL;
                end else if (funct7 == `RVF_F7_MULDIV && funct3 == `RVF_F3_DIVU) begin
                    cls = CLS_DIV;
                end
            end
            default: cls = CLS_PLAIN;
        endcase
    end

    assign accept = instr_valid && !md_wait_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect     <= 1'b0;
            jalr_pending <= 1'b0;
            flush        <= 1'b0;
            md_start     <= 1'b0;
            retire       <= 1'b0;
            commit_valid <= 1'b0;
            md_wait_q    <= 1'b0;
        end else begin
            redirect     <= jalr_pending;  // second step of jalr
            jalr_pending <= 1'b0;
            flush        <= 1'b0;
            md_start     <= 1'b0;
            retire       <= 1'b0;
            commit_valid <= 1'b0;
            if (accept) begin
                flush <= (cls != CLS_PLAIN);  // prefetched pc + 4 is useless
                case (cls)
                    CLS_JAL: begin
                        redirect     <= 1'b1;
                        commit_valid <= 1'b1;
                    end
                    CLS_JALR: begin
                        jalr_pending <= 1'b1;
                        commit_valid <= 1'b1;
                    end
                    CLS_MUL, CLS_DIV: begin
                        md_start  <= 1'b1;
                        md_wait_q <= 1'b1;
                    end
                    default: begin
                        retire       <= 1'b1;
                        commit_valid <= 1'b1;
                    end
                endcase
            end else if (md_wait_q && md_done) begin
                md_wait_q    <= 1'b0;
                retire       <= 1'b1;
                commit_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            commit_pc     <= instr_pc;
            commit_cls    <= cls;
            commit_result <= '0;
            // jalr with rs1 = x0 lands on the bare immediate
            redirect_pc   <= (cls == CLS_JAL) ? instr_pc + j_imm : {i_imm[31:1], 1'b0};
            if (cls == CLS_MUL || cls == CLS_DIV) begin
                md_is_div <= (cls == CLS_DIV);
                md_a_q    <= md_a;
                md_b_q    <= md_b;
            end
        end else if (md_wait_q && md_done) begin
            commit_result <= md_result;
        end
    end

endmodule

/* src/rvf_muldiv.sv */
`timescale 1ns/10ps
`include "rvf_macros.svh"

module rvf_muldiv (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 md_start,
    input  logic                 md_is_div,
    input  logic [`RVF_XLEN-1:0] md_a_q,
    input  logic [`RVF_XLEN-1:0] md_b_q,
    output logic                 md_busy,
    output logic                 md_done,
    output logic [`RVF_XLEN-1:0] md_result
);
    import rvf_pkg::*;

    localparam logic [4:0] LAST_STEP = 5'd31;

    instr_class_e         op_q;
    logic                 run_q;
    logic [4:0]           cnt_q;
    logic [`RVF_XLEN-1:0] acc_q;  // product or remainder
    logic [`RVF_XLEN-1:0] opa_q;  // multiplicand, or dividend turning into quotient
    logic [`RVF_XLEN-1:0] opb_q;  // multiplier or divisor
    logic [`RVF_XLEN-1:0] acc_d;
    logic [`RVF_XLEN-1:0] opa_d;
    logic [`RVF_XLEN-1:0] opb_d;
    logic [`RVF_XLEN-1:0] prod;
    logic [`RVF_XLEN:0]   shifted;
    logic [`RVF_XLEN:0]   diff;
    logic                 fits;

    // shift and add, low half only
    assign prod = opb_q[0] ? acc_q + opa_q : acc_q;

    // restoring step; a zero divisor always fits, so the quotient ends all ones
    assign shifted = {acc_q, opa_q[`RVF_XLEN-1]};
    assign diff    = shifted - {1'b0, opb_q};
    assign fits    = !diff[`RVF_XLEN];

    always_comb begin
        if (op_q == CLS_DIV) begin
            acc_d = fits ? diff[`RVF_XLEN-1:0] : shifted[`RVF_XLEN-1:0];
            opa_d = {opa_q[`RVF_XLEN-2:0], fits};
            opb_d = opb_q;
        end else begin
            acc_d = prod;
            opa_d = {opa_q[`RVF_XLEN-2:0], 1'b0};
            opb_d = {1'b0, opb_q[`RVF_XLEN-1:1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q   <= 1'b0;
            cnt_q   <= '0;
            md_done <= 1'b0;
        end else begin
            md_done <= 1'b0;
            if (md_start) begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end else if (run_q) begin
                cnt_q <= cnt_q + 5'd1;
                if (cnt_q == LAST_STEP) begin
                    run_q   <= 1'b0;
                    md_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (md_start) begin
            op_q  <= md_is_div ? CLS_DIV : CLS_MUL;
            acc_q <= '0;
            opa_q <= md_a_q;
            opb_q <= md_b_q;
        end else if (run_q) begin
            acc_q <= acc_d;
            opa_q <= opa_d;
            opb_q <= opb_d;
            if (cnt_q == LAST_STEP) begin
                // quotient for divu, product otherwise
                md_result <= (op_q == CLS_DIV) ? opa_d : acc_d;
            end
        end
    end

    assign md_busy = run_q;

endmodule

/* src/rvf_frontend_top.sv */
`timescale 1ns/10ps
`include "rvf_macros.svh"

module rvf_frontend_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_stall,
    input  logic [`RVF_XLEN-1:0]  md_a,
    input  logic [`RVF_XLEN-1:0]  md_b,
    input  logic [`RVF_XLEN-1:0]  prdata,
    input  logic                  pready,
    input  logic                  pslverr,
    output logic                  psel,
    output logic                  penable,
    output logic [`RVF_XLEN-1:0]  paddr,
    output logic                  pwrite,
    output logic                  commit_valid,
    output logic [`RVF_XLEN-1:0]  commit_pc,
    output rvf_pkg::instr_class_e commit_cls,
    output logic [`RVF_XLEN-1:0]  commit_result
);

    logic                 fetch_req;
    logic [`RVF_XLEN-1:0] fetch_pc;
    logic                 fetch_ready;
    logic                 instr_valid;
    logic [`RVF_XLEN-1:0] instr_pc;
    logic [`RVF_XLEN-1:0] instr_word;
    logic                 redirect;
    logic [`RVF_XLEN-1:0] redirect_pc;
    logic                 jalr_pending;
    logic                 flush;
    logic                 retire;
    logic                 md_start;
    logic                 md_is_div;
    logic [`RVF_XLEN-1:0] md_a_q;
    logic [`RVF_XLEN-1:0] md_b_q;
    logic                 md_busy;
    logic                 md_done;
    logic [`RVF_XLEN-1:0] md_result;
    logic                 pc_hold;

    assign pc_hold = mem_stall | md_busy;  // either one freezes the pc

    rvf_pc_gen u_pc_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_stall    (pc_hold),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .jalr_pending (jalr_pending),
        .md_start     (md_start),
        .md_done      (md_done),
        .retire       (retire),
        .fetch_ready  (fetch_ready),
        .fetch_req    (fetch_req),
        .fetch_pc     (fetch_pc)
    );

    rvf_fetch_apb u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .flush       (flush),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .fetch_ready (fetch_ready),
        .psel        (psel),
        .penable     (penable),
        .paddr       (paddr),
        .pwrite      (pwrite),
        .instr_valid (instr_valid),
        .instr_pc    (instr_pc),
        .instr_word  (instr_word)
    );

    rvf_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr_pc      (instr_pc),
        .instr_word    (instr_word),
        .md_done       (md_done),
        .md_result     (md_result),
        .md_a          (md_a),
        .md_b          (md_b),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .jalr_pending  (jalr_pending),
        .flush         (flush),
        .md_start      (md_start),
        .md_is_div     (md_is_div),
        .md_a_q        (md_a_q),
        .md_b_q        (md_b_q),
        .retire        (retire),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_cls    (commit_cls),
        .commit_result (commit_result)
    );

    rvf_muldiv u_muldiv (
        .clk       (clk),
        .rst_n     (rst_n),
        .md_start  (md_start),
        .md_is_div (md_is_div),
        .md_a_q    (md_a_q),
        .md_b_q    (md_b_q),
        .md_busy   (md_busy),
        .md_done   (md_done),
        .md_result (md_result)
    );

endmodule

/* dv/rvf_imem_model.sv */
`timescale 1ns/10ps
`include "rvf_macros.svh"

module rvf_imem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [3:0]           max_wait,
    input  logic                 psel,
    input  logic                 penable,
    input  logic [`RVF_XLEN-1:0] paddr,
    output logic [`RVF_XLEN-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr
);

    logic [`RVF_XLEN-1:0] words [0:1023];
    logic                 fail  [0:1023];  // these addresses answer with pslverr
    logic [3:0]           wait_q;
    logic [9:0]           idx;
    integer               seed = 98;

    assign idx = paddr[11:2];  // 4 KB window, higher bits alias

    // fresh wait count drawn in every setup phase
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q <= '0;
        end else if (psel && !penable) begin
            wait_q <= 4'($unsigned($random(seed)) % (max_wait + 32'd1));
        end else if (psel && penable && wait_q != 4'd0) begin
            wait_q <= wait_q - 4'd1;
        end
    end

    assign pready  = psel && penable && (wait_q == 4'd0);
    assign prdata  = pready ? words[idx] : '0;
    assign pslverr = pready && fail[idx];

    task automatic clear_all();
        int i;
        for (i = 0; i < 1024; i++) begin
            words[i] = `RVF_NOP;
            fail[i]  = 1'b0;
        end
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [31:0] word,
                              input logic err);
        words[addr[11:2]] = word;
        fail[addr[11:2]]  = err;
    endtask

endmodule

/* dv/tb_rvf_frontend.sv */
`timescale 1ns/10ps
`include "rvf_macros.svh"

module tb_rvf_frontend;
    import rvf_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int TOTAL_INSTR = 12 + 7 + 6 + 7 + 10;  // commits over all tests

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 mem_stall;
    logic [31:0]          md_a;
    logic [31:0]          md_b;
    logic [3:0]           max_wait;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 psel;
    logic                 penable;
    logic [31:0]          paddr;
    logic                 pwrite;
    logic                 commit_valid;
    logic [31:0]          commit_pc;
    instr_class_e         commit_cls;
    logic [31:0]          commit_result;

    // expected behavior per word, indexed like the memory
    instr_class_e         exp_cls  [0:1023];
    logic                 exp_jump [0:1023];
    logic [31:0]          exp_tgt  [0:1023];
    logic [31:0]          opnd_a   [0:7];  // operands per muldiv instruction, in order
    logic [31:0]          opnd_b   [0:7];
    integer               seed = 98;
    int                   errors = 0;
    int                   checks = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rvf_frontend_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_stall     (mem_stall),
        .md_a          (md_a),
        .md_b          (md_b),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .psel          (psel),
        .penable       (penable),
        .paddr         (paddr),
        .pwrite        (pwrite),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_cls    (commit_cls),
        .commit_result (commit_result)
    );

    rvf_imem_model u_imem (
        .clk      (clk),
        .rst_n    (rst_n),
        .max_wait (max_wait),
        .psel     (psel),
        .penable  (penable),
        .paddr    (paddr),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    // instruction encoders
    function automatic logic [31:0] addi_word(input logic [11:0] imm);
        return {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, `RVF_OP_JAL};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [11:0] imm);
        return {imm, 5'd0, 3'b000, 5'd1, `RVF_OP_JALR};  // rs1 = x0
    endfunction

    function automatic logic [31:0] md_word(input logic is_div);
        return {`RVF_F7_MULDIV, 5'd2, 5'd1, is_div ? `RVF_F3_DIVU : `RVF_F3_MUL, 5'd3, `RVF_OP_OP};
    endfunction

    // M extension results as the ISA defines them
    function automatic logic [31:0] md_expect(input logic is_div, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [63:0] full;
        full = a * b;
        if (!is_div) begin
            return full[31:0];
        end
        return (b == 32'd0) ? 32'hFFFF_FFFF : a / b;
    endfunction

    task automatic place(input logic [31:0] addr, input logic [31:0] word,
                         input instr_class_e cls, input logic jump,
                         input logic [31:0] tgt, input logic err);
        u_imem.store_word(addr, word, err);
        exp_cls[addr[11:2]]  = cls;
        exp_jump[addr[11:2]] = jump;
        exp_tgt[addr[11:2]]  = tgt;
    endtask

    task automatic flag_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
        $display("CHECK FAILED %s: %s expected 0x%08h actual 0x%08h", test, what, exp, act);
        errors++;
    endtask

    task automatic hold_reset();
        int i;
        @(posedge clk);
        rst_n     <= 1'b0;
        mem_stall <= 1'b0;
        u_imem.clear_all();
        for (i = 0; i < 1024; i++) begin
            exp_cls[i]  = CLS_PLAIN;  // nop fill falls through
            exp_jump[i] = 1'b0;
            exp_tgt[i]  = '0;
        end
    endtask

    // releases reset and follows n commits against the expected pc stream
    task automatic run_program(input string name, input int n, input int stall_at);
        int          errs_before;
        int          seen;
        int          gap;
        int          span;
        int          md_n;
        logic [31:0] exp_pc;
        logic [31:0] exp_res;
        logic [9:0]  k;
        logic        is_md;
        errs_before = errors;
        md_n        = 0;
        span        = 5 + ($unsigned($random(seed)) % 20);
        md_a        <= opnd_a[0];
        md_b        <= opnd_b[0];
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        fork
            begin
                seen   = 0;
                gap    = 0;
                exp_pc = `RVF_RESET_PC;
                while (seen < n) begin
                    @(negedge clk);  // outputs settled here
                    gap++;
                    if (psel) begin
                        checks++;
                        assert (pwrite == 1'b0)
                        else flag_mismatch(name, "pwrite", 32'd0, {31'd0, pwrite});
                    end
                    if (commit_valid) begin
                        k       = exp_pc[11:2];
                        is_md   = (exp_cls[k] == CLS_MUL) || (exp_cls[k] == CLS_DIV);
                        exp_res = is_md ? md_expect(exp_cls[k] == CLS_DIV, opnd_a[md_n],
                                                    opnd_b[md_n]) : 32'd0;
                        checks += 3;
                        assert (commit_pc == exp_pc)
                        else flag_mismatch(name, "commit_pc", exp_pc, commit_pc);
                        assert (commit_cls == exp_cls[k])
                        else flag_mismatch(name, "commit_cls", exp_cls[k], commit_cls);
                        assert (commit_result == exp_res)
                        else flag_mismatch(name, "commit_result", exp_res, commit_result);
                        if (is_md) begin
                            assert (gap > 33) else begin
                                $display("%s: muldiv at %08h committed after only %0d cycles",
                                         name, exp_pc, gap);
                                errors++;
                            end
                        end
                        exp_pc = exp_jump[k] ? exp_tgt[k] : exp_pc + 32'd4;
                        seen++;
                        gap = 0;
                        if (is_md) begin
                            md_n++;
                            @(posedge clk);
                            md_a <= opnd_a[md_n];  // next muldiv takes fresh operands
                            md_b <= opnd_b[md_n];
                        end
                    end
                end
            end
            begin
                if (stall_at > 0) begin
                    repeat (stall_at) @(posedge clk);
                    mem_stall <= 1'b1;
                    @(posedge clk);
                    // a setup phase here means a request was taken under the stall
                    repeat (span - 1) begin
                        @(negedge clk);
                        checks++;
                        assert (!(psel && !penable)) else begin
                            $display("%s: new APB request started while mem_stall was high",
                                     name);
                            errors++;
                        end
                        @(posedge clk);
                    end
                    mem_stall <= 1'b0;
                end
            end
        join
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("%-14s %s, %0d commits followed", name,
                 (errors == errs_before) ? "passed" : "failed", n);
    endtask

    task automatic straight_line_test();
        int i;
        hold_reset();
        max_wait <= 4'd3;
        for (i = 0; i < 12; i++) begin
            place(`RVF_RESET_PC + 4 * i, addi_word(12'(i + 1)), CLS_PLAIN, 1'b0, 0, 1'b0);
        end
        run_program("straight_line", 12, 0);
    endtask

    task automatic jal_test();
        hold_reset();
        max_wait <= 4'd2;
        place(32'h8000_0000, addi_word(12'd5), CLS_PLAIN, 1'b0, 0, 1'b0);
        place(32'h8000_0004, jal_word(21'd32), CLS_JAL, 1'b1, 32'h8000_0024, 1'b0);
        place(32'h8000_0008, addi_word(12'd9), CLS_PLAIN, 1'b0, 0, 1'b0);  // skipped
        place(32'h8000_0024, addi_word(12'd7), CLS_PLAIN, 1'b0, 0, 1'b0);
        // backward jump
        place(32'h8000_0028, jal_word(-21'd24), CLS_JAL, 1'b1, 32'h8000_0010, 1'b0);
        run_program("jal", 7, 0);
    endtask

    task automatic jalr_test();
        hold_reset();
        max_wait <= 4'd2;
        place(32'h8000_0000, addi_word(12'd3), CLS_PLAIN, 1'b0, 0, 1'b0);
        place(32'h8000_0004, jalr_word(12'h7F1), CLS_JALR, 1'b1, 32'h0000_07F0, 1'b0);
        place(32'h0000_07F0, addi_word(12'd4), CLS_PLAIN, 1'b0, 0, 1'b0);
        // negative immediate lands near the top of the address space
        place(32'h0000_07F4, jalr_word(12'h9A5), CLS_JALR, 1'b1, 32'hFFFF_F9A4, 1'b0);
        place(32'hFFFF_F9A4, addi_word(12'd6), CLS_PLAIN, 1'b0, 0, 1'b0);
        run_program("jalr", 6, 0);
    endtask

    task automatic muldiv_test();
        int i;
        hold_reset();
        max_wait <= 4'd2;
        for (i = 0; i < 8; i++) begin
            opnd_a[i] = $random(seed);
            opnd_b[i] = $random(seed);
        end
        opnd_b[3] = 32'd0;                                    // divide by zero
        opnd_b[4] = ($unsigned($random(seed)) % 16) + 32'd1;  // small divisor
        place(32'h8000_0000, md_word(1'b0), CLS_MUL, 1'b0, 0, 1'b0);
        place(32'h8000_0004, md_word(1'b1), CLS_DIV, 1'b0, 0, 1'b0);
        place(32'h8000_0008, addi_word(12'd1), CLS_PLAIN, 1'b0, 0, 1'b0);
        place(32'h8000_000C, md_word(1'b0), CLS_MUL, 1'b0, 0, 1'b0);
        place(32'h8000_0010, md_word(1'b1), CLS_DIV, 1'b0, 0, 1'b0);
        place(32'h8000_0014, md_word(1'b1), CLS_DIV, 1'b0, 0, 1'b0);
        run_program("muldiv", 7, 0);
    endtask

    task automatic stall_error_test();
        int i;
        hold_reset();
        max_wait <= 4'd2;
        for (i = 0; i < 10; i++) begin
            place(`RVF_RESET_PC + 4 * i, addi_word(12'(i + 20)), CLS_PLAIN, 1'b0, 0, 1'b0);
        end
        // jal behind a slave error must not redirect
        place(32'h8000_0010, jal_word(21'h100), CLS_PLAIN, 1'b0, 0, 1'b1);
        run_program("stall_error", 10, 6 + ($unsigned($random(seed)) % 10));
    endtask

    initial begin
        #(TOTAL_INSTR * 60 * CLK_PERIOD);
        $display("timeout: commits stopped before the tests were done");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        mem_stall = 1'b0;
        md_a      = '0;
        md_b      = '0;
        max_wait  = '0;
        opnd_a[0] = '0;
        opnd_b[0] = '0;
        straight_line_test();
        jal_test();
        jalr_test();
        muldiv_test();
        stall_error_test();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+src
src/rvf_pkg.sv
src/rvf_pc_gen.sv
src/rvf_fetch_apb.sv
src/rvf_decode.sv
src/rvf_muldiv.sv
src/rvf_frontend_top.sv
dv/rvf_imem_model.sv
dv/tb_rvf_frontend.sv
